//--- all.f
+incdir+include
logic/stq_pkg.sv
logic/mem_pkg.sv
logic/stq_entry.sv
logic/stq_ptr_ctrl.sv
logic/stq_l1d_drain.sv
logic/stq_snoop.sv
logic/stq_top.sv
verif/stq_tb.sv

//--- verif/stq_tb.sv
`timescale 1ns/10ps
`include "stq_cfg.svh"

module stq_tb;

  localparam int N_BASIC    = 40;
  localparam int N_CONFLICT = 40;
  localparam int N_FLUSH    = 60;
  localparam int N_MIXED    = 100;
  localparam int WATCHDOG_CYCLES = 40 * (N_BASIC + N_CONFLICT + N_FLUSH + N_MIXED);
  localparam int LA_W  = mem_pkg::LINE_ADDR_W;
  localparam int OFF_W = mem_pkg::LINE_OFF_W;
  localparam logic [LA_W-1:0] LINE_BASE = 'h0040010;   // small pool of lines

  localparam logic [2:0] M_FREE = 3'd0;
  localparam logic [2:0] M_OPER = 3'd1;
  localparam logic [2:0] M_WCMT = 3'd2;
  localparam logic [2:0] M_CMT  = 3'd3;   // committed or in flight to l1d
  localparam logic [2:0] M_DEAD = 3'd4;

  typedef struct packed {
    logic [2:0]           state;
    logic [`CMT_ID_W-1:0] cmt_id;
    logic [`PADDR_W-1:0]  paddr;
    logic [1:0]           size;
    logic [`DATA_W-1:0]   data;
    logic                 aok;
    logic                 dok;
  } model_t;

  logic                 clk = 1'b0;
  logic                 reset_n;
  stq_pkg::disp_t       disp;
  stq_pkg::ex_upd_t     ex_upd;
  stq_pkg::done_t       commit;
  logic                 flush;
  mem_pkg::l1d_resp_t   l1d_resp;
  mem_pkg::snoop_req_t  snoop_req;
  logic                 credit;
  stq_pkg::done_t       done;
  mem_pkg::l1d_req_t    l1d_req;
  mem_pkg::snoop_resp_t snoop_resp;

  model_t               m [`STQ_DEPTH];
  int                   cmt_q[$];     // live uncommitted slots, program order
  int                   drain_q[$];   // committed slots not yet drained, oldest first
  int                   credits;
  int                   in_slot;
  int                   disp_cnt;
  logic [`CMT_ID_W-1:0] next_cmt;
  logic                 exp_done_v;
  int                   exp_done_slot;
  logic                 snp_exp_v;
  logic [`LINE_B-1:0]   snp_exp_be;
  logic [`LINE_W-1:0]   snp_exp_data;
  logic                 l1d_busy;
  int                   l1d_delay;
  int                   err_cnt;
  int                   test_err;
  int                   tests_run;
  int                   tests_ok;

  stq_top u_stq_top (
    .i_clk        (clk),
    .i_reset_n    (reset_n),
    .i_disp       (disp),
    .i_ex_upd     (ex_upd),
    .i_commit     (commit),
    .i_flush      (flush),
    .i_l1d_resp   (l1d_resp),
    .i_snoop_req  (snoop_req),
    .o_credit     (credit),
    .o_done       (done),
    .o_l1d_req    (l1d_req),
    .o_snoop_resp (snoop_resp)
  );

  always #50 clk = ~clk;

  // 1 << size bytes starting at the line offset
  function automatic logic [`LINE_B-1:0] store_be(model_t s);
    logic [`LINE_B-1:0] be;
    int                 off;
    be  = '0;
    off = s.paddr[OFF_W-1:0];
    for (int b = 0; b < (1 << s.size); b++) begin
      if (off + b < `LINE_B) be[off + b] = 1'b1;
    end
    return be;
  endfunction

  // all four data bytes placed from the offset up
  function automatic logic [`LINE_W-1:0] store_wide(model_t s);
    logic [`LINE_W-1:0] w;
    int                 off;
    w   = '0;
    off = s.paddr[OFF_W-1:0];
    for (int b = 0; b < 4; b++) begin
      if (off + b < `LINE_B) w[8*(off+b) +: 8] = s.data[8*b +: 8];
    end
    return w;
  endfunction

  task automatic report_mismatch(string name, logic [`LINE_W-1:0] exp, logic [`LINE_W-1:0] got);
    $display("error: %s exp %h got %h", name, exp, got);
    err_cnt++;
    test_err++;
  endtask

  task automatic report_note(string msg);
    $display("%s", msg);
    err_cnt++;
    test_err++;
  endtask

  // outputs seen here reflect the last rising edge
  task automatic check_outputs();
    int s;
    if (credit === 1'b1) credits++;
    if (credits > `STQ_DEPTH) report_note("credit returned beyond queue depth");
    if (done.valid !== exp_done_v) begin
      report_mismatch("o_done.valid", exp_done_v, done.valid);
    end else if (exp_done_v && done.cmt_id !== m[exp_done_slot].cmt_id) begin
      report_mismatch("o_done.cmt_id", m[exp_done_slot].cmt_id, done.cmt_id);
    end
    if (exp_done_v) m[exp_done_slot].state = M_WCMT;
    exp_done_v = 1'b0;
    if (l1d_req.valid === 1'b1) begin
      if (l1d_busy) begin
        report_note("l1d request issued while another one is outstanding");
      end else if (drain_q.size() == 0) begin
        report_note("l1d request issued with no committed store pending");
      end else begin
        s = drain_q[0];
        if (l1d_req.line_addr !== m[s].paddr[`PADDR_W-1:OFF_W])
          report_mismatch("o_l1d_req.line_addr", m[s].paddr[`PADDR_W-1:OFF_W], l1d_req.line_addr);
        if (l1d_req.be !== store_be(m[s]))
          report_mismatch("o_l1d_req.be", store_be(m[s]), l1d_req.be);
        if (l1d_req.data !== store_wide(m[s]))
          report_mismatch("o_l1d_req.data", store_wide(m[s]), l1d_req.data);
        l1d_busy  = 1'b1;
        l1d_delay = $urandom % 5;
      end
    end
    if (snoop_resp.valid !== snp_exp_v) begin
      report_mismatch("o_snoop_resp.valid", snp_exp_v, snoop_resp.valid);
    end else if (snp_exp_v) begin
      if (snoop_resp.be !== snp_exp_be)
        report_mismatch("o_snoop_resp.be", snp_exp_be, snoop_resp.be);
      if (snoop_resp.data !== snp_exp_data)
        report_mismatch("o_snoop_resp.data", snp_exp_data, snoop_resp.data);
    end
  endtask

  // expected merge uses the state before this cycle's commit or response
  task automatic drive_snoop();
    logic [`LINE_B-1:0] be;
    logic [`LINE_W-1:0] wide;
    snoop_req.valid     = ($urandom % 2) == 0;
    snoop_req.line_addr = LINE_BASE + LA_W'($urandom % 5);
    snp_exp_v    = snoop_req.valid;
    snp_exp_be   = '0;
    snp_exp_data = '0;
    foreach (drain_q[i]) begin
      if (m[drain_q[i]].paddr[`PADDR_W-1:OFF_W] == snoop_req.line_addr) begin
        be   = store_be(m[drain_q[i]]);
        wide = store_wide(m[drain_q[i]]);
        for (int b = 0; b < `LINE_B; b++) begin
          if (be[b]) begin
            snp_exp_be[b]         = 1'b1;
            snp_exp_data[8*b +: 8] = wide[8*b +: 8];   // younger overwrites
          end
        end
      end
    end
  endtask

  task automatic drive_l1d(int conf_pct);
    l1d_resp = '0;
    if (l1d_busy) begin
      if (l1d_delay == 0) begin
        l1d_resp.valid    = 1'b1;
        l1d_resp.conflict = ($urandom % 100) < conf_pct;
        l1d_busy          = 1'b0;
        if (!l1d_resp.conflict) begin
          m[drain_q[0]].state = M_FREE;
          void'(drain_q.pop_front());
        end
      end else begin
        l1d_delay--;
      end
    end
  endtask

  task automatic drive_front(int nst, int flush_pct);
    int               cand[$];
    int               s;
    int               sz;
    int               off;
    stq_pkg::ex_upd_t u;
    disp   = '0;
    ex_upd = '0;
    commit = '0;
    flush  = (flush_pct > 0) && (($urandom % 100) < flush_pct);
    if (flush) begin
      foreach (cmt_q[i]) m[cmt_q[i]].state = M_DEAD;
      cmt_q.delete();
    end else begin
      if (cmt_q.size() > 0 && m[cmt_q[0]].state == M_WCMT && ($urandom % 2) == 0) begin
        s = cmt_q.pop_front();   // in order, oldest only
        commit.valid  = 1'b1;
        commit.cmt_id = m[s].cmt_id;
        m[s].state    = M_CMT;
        drain_q.push_back(s);
      end
      for (int i = 0; i < `STQ_DEPTH; i++) begin
        if (m[i].state == M_OPER && !(m[i].aok && m[i].dok)) cand.push_back(i);
      end
      if (cand.size() > 0 && ($urandom % 4) != 0) begin
        s       = cand[$urandom % cand.size()];
        u       = '0;
        u.valid = 1'b1;
        u.idx   = `STQ_IDX_W'(s);
        if (!m[s].aok && (m[s].dok || ($urandom % 2) == 0)) begin
          sz  = $urandom % 3;
          off = ($urandom % `LINE_B) & ~((1 << sz) - 1);   // naturally aligned
          m[s].paddr = {LINE_BASE + LA_W'($urandom % 4), OFF_W'(off)};
          m[s].size  = sz;
          m[s].aok   = 1'b1;
          u.payload.addr.paddr = m[s].paddr;
          u.payload.addr.size  = stq_pkg::st_size_t'(sz);
        end else begin
          m[s].data = $urandom;
          m[s].dok  = 1'b1;
          u.is_data = 1'b1;
          u.payload.wdata.data = m[s].data;
        end
        ex_upd = u;
        if (m[s].aok && m[s].dok) begin
          exp_done_v    = 1'b1;
          exp_done_slot = s;
        end
      end
    end
    if (disp_cnt < nst && credits > 0 && ($urandom % 3) != 0) begin
      disp.valid         = 1'b1;
      disp.cmt_id        = next_cmt;
      m[in_slot]         = '0;
      m[in_slot].cmt_id  = next_cmt;
      m[in_slot].state   = flush ? M_DEAD : M_OPER;   // killed by a same cycle flush
      if (!flush) cmt_q.push_back(in_slot);
      in_slot  = (in_slot + 1) % `STQ_DEPTH;
      next_cmt = next_cmt + 1'b1;
      credits--;
      disp_cnt++;
    end
  endtask

  task automatic run_test(string name, int nst, int conf_pct, int flush_pct);
    disp_cnt = 0;
    test_err = 0;
    do begin
      @(negedge clk);
      check_outputs();
      drive_snoop();
      drive_l1d(conf_pct);
      drive_front(nst, flush_pct);
    end while (!(disp_cnt == nst && credits == `STQ_DEPTH && cmt_q.size() == 0 &&
                 drain_q.size() == 0 && !l1d_busy && !exp_done_v));
    tests_run++;
    if (test_err == 0) tests_ok++;
    $display("%-9s %0d stores, %0d errors, %s", name, nst, test_err,
             (test_err == 0) ? "ok" : "FAILED");
  endtask

  initial begin
    void'($urandom(32'h8799));
    reset_n   = 1'b0;
    disp      = '0;
    ex_upd    = '0;
    commit    = '0;
    flush     = 1'b0;
    l1d_resp  = '0;
    snoop_req = '0;
    foreach (m[i]) m[i] = '0;
    credits    = `STQ_DEPTH;
    in_slot    = 0;
    disp_cnt   = 0;
    next_cmt   = '0;
    exp_done_v = 1'b0;
    snp_exp_v  = 1'b0;
    l1d_busy   = 1'b0;
    l1d_delay  = 0;
    err_cnt    = 0;
    test_err   = 0;
    tests_run  = 0;
    tests_ok   = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    if (credit !== 1'b0 || done.valid !== 1'b0 || l1d_req.valid !== 1'b0 ||
        snoop_resp.valid !== 1'b0) begin
      report_note("outputs not idle during reset");
    end
    reset_n = 1'b1;
    run_test("basic", N_BASIC, 0, 0);
    run_test("conflict", N_CONFLICT, 30, 0);
    run_test("flush", N_FLUSH, 0, 4);
    run_test("mixed", N_MIXED, 25, 3);
    @(negedge clk);
    check_outputs();   // last snoop response
    $display("tests %0d, ok %0d, failing %0d, errors %0d",
             tests_run, tests_ok, tests_run - tests_ok, err_cnt);
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * 100);
    $display("watchdog expired after %0d cycles, the queue never drained", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule

//--- logic/stq_top.sv
`timescale 1ns/10ps
`include "stq_cfg.svh"

module stq_top (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  stq_pkg::disp_t       i_disp,
  input  stq_pkg::ex_upd_t     i_ex_upd,
  input  stq_pkg::done_t       i_commit,
  input  logic                 i_flush,
  input  mem_pkg::l1d_resp_t   i_l1d_resp,
  input  mem_pkg::snoop_req_t  i_snoop_req,
  output logic                 o_credit,
  output stq_pkg::done_t       o_done,
  output mem_pkg::l1d_req_t    o_l1d_req,
  output mem_pkg::snoop_resp_t o_snoop_resp
);

  logic [`STQ_DEPTH-1:0] w_load_oh;
  logic [`STQ_DEPTH-1:0] w_head_oh;
  logic [`STQ_DEPTH-1:0] w_finish_oh;
  logic [`STQ_IDX_W-1:0] w_head_idx;
  stq_pkg::stq_entry_t   w_entries [`STQ_DEPTH];
  stq_pkg::done_t        w_done [`STQ_DEPTH];
  stq_pkg::stq_entry_t   w_head_entry;
  logic                  w_drain_issue;
  logic                  w_l1d_done;
  logic                  w_l1d_conflict;

  stq_ptr_ctrl u_ptr_ctrl (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_push      (i_disp.valid),
    .i_finish_oh (w_finish_oh),
    .o_in_idx    (),               // load select is already one-hot
    .o_head_idx  (w_head_idx),
    .o_head_oh   (w_head_oh),
    .o_load_oh   (w_load_oh),
    .o_credit    (o_credit)
  );

  for (genvar i = 0; i < `STQ_DEPTH; i++) begin : g_entry
    stq_entry u_entry (
      .i_clk          (i_clk),
      .i_reset_n      (i_reset_n),
      .i_load         (w_load_oh[i] & i_disp.valid),
      .i_disp         (i_disp),
      .i_ex_upd       (i_ex_upd),
      .i_my_idx_hit   (i_ex_upd.idx == `STQ_IDX_W'(i)),
      .i_commit_valid (i_commit.valid),
      .i_commit_id    (i_commit.cmt_id),
      .i_flush        (i_flush),
      .i_drain_issue  (w_drain_issue),
      .i_l1d_done     (w_l1d_done),
      .i_l1d_conflict (w_l1d_conflict),
      .i_head         (w_head_oh[i]),
      .o_entry        (w_entries[i]),
      .o_done         (w_done[i]),
      .o_finish       (w_finish_oh[i])
    );
  end

  assign w_head_entry = w_entries[w_head_idx];

  // one update per cycle, so at most one entry completes
  always_comb begin
    o_done = '0;
    for (int i = 0; i < `STQ_DEPTH; i++) begin
      if (w_done[i].valid) begin
        o_done = w_done[i];
      end
    end
  end

  stq_l1d_drain u_l1d_drain (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_head_entry   (w_head_entry),
    .i_l1d_resp     (i_l1d_resp),
    .o_drain_issue  (w_drain_issue),
    .o_l1d_done     (w_l1d_done),
    .o_l1d_conflict (w_l1d_conflict),
    .o_l1d_req      (o_l1d_req)
  );

  stq_snoop u_snoop (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_entries    (w_entries),
    .i_head_idx   (w_head_idx),
    .i_snoop_req  (i_snoop_req),
    .o_snoop_resp (o_snoop_resp)
  );

endmodule

//--- logic/stq_snoop.sv
`timescale 1ns/10ps
`include "stq_cfg.svh"

module stq_snoop (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  stq_pkg::stq_entry_t   i_entries [`STQ_DEPTH],
  input  logic [`STQ_IDX_W-1:0] i_head_idx,
  input  mem_pkg::snoop_req_t   i_snoop_req,
  output mem_pkg::snoop_resp_t  o_snoop_resp
);

  logic               r_valid;
  logic [`LINE_B-1:0] r_be;
  logic [`LINE_W-1:0] r_data;
  logic [`LINE_B-1:0] w_be;
  logic [`LINE_W-1:0] w_data;

  // oldest first, so a younger store overwrites older bytes
  always_comb begin
    logic [`STQ_IDX_W-1:0]          idx;
    logic [mem_pkg::LINE_OFF_W-1:0] off;
    logic                           hit;
    logic [`LINE_B-1:0]             be;
    logic [`LINE_W-1:0]             data;
    w_be   = '0;
    w_data = '0;
    for (int k = 0; k < `STQ_DEPTH; k++) begin
      idx  = i_head_idx + `STQ_IDX_W'(k);
      off  = i_entries[idx].paddr[mem_pkg::LINE_OFF_W-1:0];
      hit  = ((i_entries[idx].state == stq_pkg::COMMITTED) |
              (i_entries[idx].state == stq_pkg::L1D_WAIT)) &
             (i_entries[idx].paddr[`PADDR_W-1:mem_pkg::LINE_OFF_W] == i_snoop_req.line_addr);
      be   = hit ? mem_pkg::line_be(i_entries[idx].size, off) : '0;
      data = mem_pkg::line_data(i_entries[idx].data, off);
      for (int b = 0; b < `LINE_B; b++) begin
        if (be[b]) begin
          w_data[8*b +: 8] = data[8*b +: 8];
        end
      end
      w_be = w_be | be;
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= i_snoop_req.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_be   <= i_snoop_req.valid ? w_be : '0;   // zero when nothing was asked
    r_data <= i_snoop_req.valid ? w_data : '0;
  end

  assign o_snoop_resp = '{valid: r_valid, be: r_be, data: r_data};

endmodule

//--- logic/stq_l1d_drain.sv
`timescale 1ns/10ps
`include "stq_cfg.svh"

module stq_l1d_drain (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  stq_pkg::stq_entry_t i_head_entry,
  input  mem_pkg::l1d_resp_t  i_l1d_resp,
  output logic                o_drain_issue,
  output logic                o_l1d_done,
  output logic                o_l1d_conflict,
  output mem_pkg::l1d_req_t   o_l1d_req
);

  logic                                r_outstanding;
  logic                                r_req_valid;
  logic [mem_pkg::LINE_ADDR_W-1:0]     r_req_line;
  logic [`LINE_B-1:0]                  r_req_be;
  logic [`LINE_W-1:0]                  r_req_data;
  logic [mem_pkg::LINE_OFF_W-1:0]      w_offset;

  assign w_offset = i_head_entry.paddr[mem_pkg::LINE_OFF_W-1:0];

  // one write in flight at a time
  assign o_drain_issue  = (i_head_entry.state == stq_pkg::COMMITTED) & ~r_outstanding;
  assign o_l1d_done     = i_l1d_resp.valid & r_outstanding;
  assign o_l1d_conflict = i_l1d_resp.valid & r_outstanding & i_l1d_resp.conflict;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_outstanding <= 1'b0;
      r_req_valid   <= 1'b0;
    end else begin
      r_req_valid <= o_drain_issue;   // single cycle pulse
      if (o_drain_issue) begin
        r_outstanding <= 1'b1;
      end else if (o_l1d_done) begin
        r_outstanding <= 1'b0;        // clean or conflict, head decides
      end
    end
  end

  // line payload, rebuilt from the entry on every replay
  always_ff @(posedge i_clk) begin
    if (o_drain_issue) begin
      r_req_line <= i_head_entry.paddr[`PADDR_W-1:mem_pkg::LINE_OFF_W];
      r_req_be   <= mem_pkg::line_be(i_head_entry.size, w_offset);
      r_req_data <= mem_pkg::line_data(i_head_entry.data, w_offset);
    end
  end

  assign o_l1d_req = '{
    valid:     r_req_valid,
    line_addr: r_req_line,
    be:        r_req_be,
    data:      r_req_data
  };

endmodule

//--- logic/stq_ptr_ctrl.sv
`timescale 1ns/10ps
`include "stq_cfg.svh"

module stq_ptr_ctrl (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_push,
  input  logic [`STQ_DEPTH-1:0] i_finish_oh,
  output logic [`STQ_IDX_W-1:0] o_in_idx,
  output logic [`STQ_IDX_W-1:0] o_head_idx,
  output logic [`STQ_DEPTH-1:0] o_head_oh,
  output logic [`STQ_DEPTH-1:0] o_load_oh,
  output logic                  o_credit
);

  localparam logic [`STQ_IDX_W:0] DEPTH_CNT = `STQ_DEPTH;

  logic [`STQ_IDX_W-1:0] r_in_ptr;
  logic [`STQ_IDX_W-1:0] r_out_ptr;
  logic [`STQ_IDX_W:0]   r_count;
  logic                  w_full;
  logic                  w_push;
  logic                  w_pop;

  assign w_full = (r_count == DEPTH_CNT);
  assign w_push = i_push & ~w_full;           // credits normally prevent a full push
  assign w_pop  = |(i_finish_oh & o_head_oh); // only the head retires

  assign o_in_idx   = r_in_ptr;
  assign o_head_idx = r_out_ptr;
  assign o_load_oh  = w_full ? '0 : (`STQ_DEPTH'(1) << r_in_ptr);
  assign o_head_oh  = `STQ_DEPTH'(1) << r_out_ptr;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_ptr  <= '0;
      r_out_ptr <= '0;
      r_count   <= '0;
      o_credit  <= 1'b0;
    end else begin
      if (w_push) begin
        r_in_ptr <= r_in_ptr + 1'b1;   // wraps modulo depth
      end
      if (w_pop) begin
        r_out_ptr <= r_out_ptr + 1'b1;
      end
      if (w_push & ~w_pop) begin
        r_count <= r_count + 1'b1;
      end else if (w_pop & ~w_push) begin
        r_count <= r_count - 1'b1;
      end
      o_credit <= w_pop;   // one credit back per freed entry
    end
  end

endmodule

//--- logic/stq_entry.sv
`timescale 1ns/10ps
`include "stq_cfg.svh"

module stq_entry (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_load,
  input  stq_pkg::disp_t       i_disp,
  input  stq_pkg::ex_upd_t     i_ex_upd,
  input  logic                 i_my_idx_hit,
  input  logic                 i_commit_valid,
  input  logic [`CMT_ID_W-1:0] i_commit_id,
  input  logic                 i_flush,
  input  logic                 i_drain_issue,
  input  logic                 i_l1d_done,
  input  logic                 i_l1d_conflict,
  input  logic                 i_head,
  output stq_pkg::stq_entry_t  o_entry,
  output stq_pkg::done_t       o_done,
  output logic                 o_finish
);

  stq_pkg::stq_entry_t r_entry;
  stq_pkg::stq_entry_t w_entry_next;
  logic                r_done;
  logic                w_oper_done;   // second half arrived this cycle
  logic                w_upd_hit;
  logic                w_cmt_match;

  assign w_upd_hit   = i_ex_upd.valid & i_my_idx_hit;
  assign w_cmt_match = i_commit_valid & (i_commit_id == r_entry.cmt_id);

  // retire only from the head, either drained cleanly or killed
  assign o_finish = i_head &
                    ((r_entry.state == stq_pkg::DEAD) |
                     ((r_entry.state == stq_pkg::L1D_WAIT) & i_l1d_done & ~i_l1d_conflict));

  always_comb begin
    w_entry_next = r_entry;
    w_oper_done  = 1'b0;
    case (r_entry.state)
      stq_pkg::INIT: begin
        if (i_load) begin
          w_entry_next.cmt_id  = i_disp.cmt_id;
          w_entry_next.addr_ok = 1'b0;
          w_entry_next.data_ok = 1'b0;
          w_entry_next.state   = i_flush ? stq_pkg::DEAD : stq_pkg::WAIT_OPER;
        end
      end
      stq_pkg::WAIT_OPER: begin
        if (w_upd_hit) begin
          if (i_ex_upd.is_data) begin
            w_entry_next.data    = i_ex_upd.payload.wdata.data;
            w_entry_next.data_ok = 1'b1;
          end else begin
            w_entry_next.paddr   = i_ex_upd.payload.addr.paddr;
            w_entry_next.size    = i_ex_upd.payload.addr.size;
            w_entry_next.addr_ok = 1'b1;
          end
        end
        if (i_flush) begin
          w_entry_next.state = stq_pkg::DEAD;
        end else if (w_entry_next.addr_ok & w_entry_next.data_ok) begin
          w_entry_next.state = stq_pkg::WAIT_COMMIT;
          w_oper_done        = 1'b1;
        end
      end
      stq_pkg::WAIT_COMMIT: begin
        if (i_flush) begin
          w_entry_next.state = stq_pkg::DEAD;
        end else if (w_cmt_match) begin
          w_entry_next.state = stq_pkg::COMMITTED;
        end
      end
      stq_pkg::COMMITTED: begin
        // committed stores survive a flush
        if (i_head & i_drain_issue) begin
          w_entry_next.state = stq_pkg::L1D_WAIT;
        end
      end
      stq_pkg::L1D_WAIT: begin
        if (i_head & i_l1d_done) begin
          w_entry_next.state = i_l1d_conflict ? stq_pkg::COMMITTED : stq_pkg::INIT;
        end
      end
      stq_pkg::DEAD: begin
        if (o_finish) begin
          w_entry_next.state = stq_pkg::INIT;
        end
      end
      default: begin
        w_entry_next.state = stq_pkg::INIT;
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_entry.state   <= stq_pkg::INIT;
      r_entry.addr_ok <= 1'b0;
      r_entry.data_ok <= 1'b0;
      r_done          <= 1'b0;
    end else begin
      r_entry <= w_entry_next;
      r_done  <= w_oper_done;   // done pulse for the cycle after
    end
  end

  assign o_entry       = r_entry;
  assign o_done.valid  = r_done;
  assign o_done.cmt_id = r_entry.cmt_id;

endmodule

//--- logic/mem_pkg.sv
`include "stq_cfg.svh"

package mem_pkg;

  localparam int LINE_OFF_W  = $clog2(`LINE_B);
  localparam int LINE_ADDR_W = `PADDR_W - LINE_OFF_W;

  typedef struct packed {
    logic                   valid;
    logic [LINE_ADDR_W-1:0] line_addr;
    logic [`LINE_B-1:0]     be;
    logic [`LINE_W-1:0]     data;
  } l1d_req_t;

  typedef struct packed {
    logic valid;
    logic conflict;   // write dropped, must be replayed
  } l1d_resp_t;

  typedef struct packed {
    logic                   valid;
    logic [LINE_ADDR_W-1:0] line_addr;
  } snoop_req_t;

  typedef struct packed {
    logic               valid;
    logic [`LINE_B-1:0] be;
    logic [`LINE_W-1:0] data;
  } snoop_resp_t;

  // byte enables of one store within its line
  function automatic logic [`LINE_B-1:0] line_be(stq_pkg::st_size_t size,
                                                 logic [LINE_OFF_W-1:0] offset);
    logic [`LINE_B-1:0] mask;
    case (size)
      stq_pkg::SIZE_B: mask = `LINE_B'('h1);
      stq_pkg::SIZE_H: mask = `LINE_B'('h3);
      default:         mask = `LINE_B'('hf);
    endcase
    return mask << offset;
  endfunction

  function automatic logic [`LINE_W-1:0] line_data(logic [`DATA_W-1:0] data,
                                                   logic [LINE_OFF_W-1:0] offset);
    logic [`LINE_W-1:0] wide;
    wide = `LINE_W'(data);
    return wide << {offset, 3'b000};   // byte offset to bit offset
  endfunction

endpackage

//--- logic/stq_pkg.sv
`include "stq_cfg.svh"

package stq_pkg;

  typedef enum logic [2:0] {
    INIT,
    WAIT_OPER,     // address and/or data still missing
    WAIT_COMMIT,
    COMMITTED,
    L1D_WAIT,      // write in flight to the l1d
    DEAD
  } stq_state_t;

  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2
  } st_size_t;

  typedef struct packed {
    logic                 valid;
    logic [`CMT_ID_W-1:0] cmt_id;
  } disp_t;

  // address half of a store
  typedef struct packed {
    logic [`PADDR_W-1:0] paddr;
    st_size_t            size;
  } ex_addr_t;

  typedef struct packed {
    logic [`DATA_W-1:0] data;
    logic [1:0]         pad;
  } ex_data_t;

  // one payload word, read as address or data depending on is_data
  typedef union packed {
    ex_addr_t addr;
    ex_data_t wdata;
  } ex_payload_u;

  typedef struct packed {
    logic                  valid;
    logic                  is_data;
    logic [`STQ_IDX_W-1:0] idx;
    ex_payload_u           payload;
  } ex_upd_t;

  typedef struct packed {
    stq_state_t           state;
    logic [`CMT_ID_W-1:0] cmt_id;
    logic [`PADDR_W-1:0]  paddr;
    st_size_t             size;
    logic [`DATA_W-1:0]   data;
    logic                 addr_ok;
    logic                 data_ok;
  } stq_entry_t;

  typedef struct packed {
    logic                 valid;
    logic [`CMT_ID_W-1:0] cmt_id;
  } done_t;

endpackage

//--- include/stq_cfg.svh
`ifndef STQ_CFG_SVH
`define STQ_CFG_SVH

// queue geometry
`define STQ_DEPTH 8
`define STQ_IDX_W 3

// datapath widths
`define PADDR_W   32
`define DATA_W    32
`define LINE_B    16   // bytes per l1d line
`define LINE_W    128
`define CMT_ID_W  6    // rob commit id

`endif
